/* src/uart_pkg.sv */
// Serial line format shared by the receiver, the transmitter and the testbench.
// One frame is a low start bit, DATA_BITS data bits LSB first and a high stop bit.

package uart_pkg;

  // Clock cycles per serial bit, kept short for simulation
  localparam int CLK_PER_BIT = 16;
  localparam int DATA_BITS   = 8;

  localparam int CTR_W = $clog2(CLK_PER_BIT);
  localparam int IDX_W = $clog2(DATA_BITS);

  typedef logic [DATA_BITS-1:0] byte_t;
  typedef logic [CTR_W-1:0]     bit_ctr_t;
  typedef logic [IDX_W-1:0]     bit_idx_t;

  // Counter value on the last cycle of a bit
  localparam bit_ctr_t BIT_END = bit_ctr_t'(CLK_PER_BIT - 1);

  // Counter value half a bit after the start edge
  localparam bit_ctr_t HALF_END = bit_ctr_t'(CLK_PER_BIT / 2 - 1);

  // Index of the last data bit
  localparam bit_idx_t IDX_LAST = bit_idx_t'(DATA_BITS - 1);

endpackage

/* src/fifo_pkg.sv */
// Sizes and types of the byte FIFO between receiver and transmitter.

package fifo_pkg;

  localparam int FIFO_DEPTH = 8;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  // One extra bit so a full FIFO can be told from an empty one
  typedef logic [PTR_W:0] count_t;

  localparam count_t FULL_COUNT = count_t'(FIFO_DEPTH);

endpackage

/* src/serial_rx.sv */
// Serial receiver. Samples rx at mid-bit and offers each good byte on a
// valid/ready port; reports bad stop bits and bytes lost to a pending one.

module serial_rx (
  input  logic            clk,
  input  logic            rst,
  input  logic            rx,
  output logic            rx_valid,
  input  logic            rx_ready,
  output uart_pkg::byte_t rx_data,
  output logic            frame_error,
  output logic            overrun
);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t             state;
  logic               rx_meta;
  logic               rx_sync;
  logic               rx_prev;
  uart_pkg::bit_ctr_t ctr;
  uart_pkg::bit_idx_t idx;
  uart_pkg::byte_t    shift;
  logic               half_done;
  logic               bit_done;
  logic               stop_sample;
  logic               load_byte;

  // Two-flop synchronizer, then one more stage for edge detection
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign half_done   = (ctr == uart_pkg::HALF_END);
  assign bit_done    = (ctr == uart_pkg::BIT_END);
  assign stop_sample = (state == S_STOP) && bit_done;

  // Good stop bit and no byte still waiting for the FIFO
  assign load_byte = stop_sample && rx_sync && !(rx_valid && !rx_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      ctr         <= '0;
      idx         <= '0;
      rx_valid    <= 1'b0;
      frame_error <= 1'b0;
      overrun     <= 1'b0;
    end else begin
      frame_error <= 1'b0;
      overrun     <= 1'b0;
      if (rx_valid && rx_ready) begin
        rx_valid <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          ctr <= '0;
          if (rx_prev && !rx_sync) begin
            state <= S_START;
          end
        end
        S_START: begin
          ctr <= ctr + 1'b1;
          // Half a bit in, the line must still be low
          if (half_done) begin
            ctr   <= '0;
            idx   <= '0;
            state <= rx_sync ? S_IDLE : S_DATA;
          end
        end
        S_DATA: begin
          ctr <= ctr + 1'b1;
          if (bit_done) begin
            ctr <= '0;
            idx <= idx + 1'b1;
            if (idx == uart_pkg::IDX_LAST) begin
              state <= S_STOP;
            end
          end
        end
        S_STOP: begin
          ctr <= ctr + 1'b1;
          if (bit_done) begin
            state <= S_IDLE;
            if (!rx_sync) begin
              frame_error <= 1'b1;
            end else if (load_byte) begin
              rx_valid <= 1'b1;
            end else begin
              overrun <= 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state == S_DATA && bit_done) begin
      shift <= {rx_sync, shift[uart_pkg::DATA_BITS-1:1]};
    end
    if (load_byte) begin
      rx_data <= shift;
    end
  end

  a_data_held: assert property (@(posedge clk) disable iff (rst)
    rx_valid && !rx_ready |=> rx_valid && $stable(rx_data));

  a_one_report: assert property (@(posedge clk) disable iff (rst)
    !(frame_error && overrun));

endmodule

/* src/byte_fifo.sv */
// First-word-fall-through byte FIFO. The head entry is always on tx_data
// while tx_valid is high; both sides use valid/ready.

module byte_fifo (
  input  logic            clk,
  input  logic            rst,
  input  logic            rx_valid,
  output logic            rx_ready,
  input  uart_pkg::byte_t rx_data,
  output logic            tx_valid,
  input  logic            tx_ready,
  output uart_pkg::byte_t tx_data
);

  uart_pkg::byte_t  mem [fifo_pkg::FIFO_DEPTH];
  fifo_pkg::ptr_t   wr_ptr;
  fifo_pkg::ptr_t   rd_ptr;
  fifo_pkg::count_t count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full     = (count == fifo_pkg::FULL_COUNT);
  assign rx_ready = !full;
  assign tx_valid = (count != '0);
  assign tx_data  = mem[rd_ptr];

  assign wr_en = rx_valid && rx_ready;
  assign rd_en = tx_valid && tx_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= rx_data;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_range: assert property (@(posedge clk) disable iff (rst)
    count <= fifo_pkg::FULL_COUNT);

  // A full FIFO must not take another byte
  a_no_write_full: assert property (@(posedge clk) disable iff (rst)
    full |=> wr_ptr == $past(wr_ptr));

endmodule

/* src/serial_tx.sv */
// Serial transmitter. Takes one byte per valid/ready transfer and sends it
// as start bit, eight data bits LSB first and stop bit. tx_hold pauses it.

module serial_tx (
  input  logic            clk,
  input  logic            rst,
  input  logic            tx_hold,
  input  logic            tx_valid,
  output logic            tx_ready,
  input  uart_pkg::byte_t tx_data,
  output logic            busy,
  output logic            tx
);

  typedef enum logic [1:0] {IDLE, START_BIT, DATA, STOP_BIT} state_t;

  state_t             state_d, state_q;
  logic               hold_q;
  uart_pkg::byte_t    data_d, data_q;
  logic               busy_d, busy_q;
  logic               tx_d, tx_q;
  uart_pkg::bit_ctr_t ctr_d, ctr_q;
  uart_pkg::bit_idx_t idx_d, idx_q;
  logic               accept;

  assign tx       = tx_q;
  assign busy     = busy_q;
  assign tx_ready = (state_q == IDLE) && !hold_q;
  assign accept   = tx_valid && tx_ready;

  // tx_d carries the value of the next bit, so tx lines up with the state
  always_comb begin
    state_d = state_q;
    data_d  = data_q;
    busy_d  = 1'b1;
    tx_d    = tx_q;
    ctr_d   = ctr_q + 1'b1;
    idx_d   = idx_q;

    case (state_q)
      IDLE: begin
        tx_d   = 1'b1;
        ctr_d  = '0;
        busy_d = hold_q;
        if (accept) begin
          data_d  = tx_data;
          tx_d    = 1'b0;
          busy_d  = 1'b1;
          state_d = START_BIT;
        end
      end
      START_BIT: begin
        if (ctr_q == uart_pkg::BIT_END) begin
          ctr_d   = '0;
          idx_d   = '0;
          tx_d    = data_q[0];
          state_d = DATA;
        end
      end
      DATA: begin
        if (ctr_q == uart_pkg::BIT_END) begin
          ctr_d = '0;
          idx_d = idx_q + 1'b1;
          if (idx_q == uart_pkg::IDX_LAST) begin
            tx_d    = 1'b1;
            state_d = STOP_BIT;
          end else begin
            tx_d = data_q[idx_d];
          end
        end
      end
      STOP_BIT: begin
        if (ctr_q == uart_pkg::BIT_END) begin
          ctr_d   = '0;
          busy_d  = hold_q;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      hold_q  <= 1'b0;
      busy_q  <= 1'b0;
      tx_q    <= 1'b1;
      ctr_q   <= '0;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      hold_q  <= tx_hold;
      busy_q  <= busy_d;
      tx_q    <= tx_d;
      ctr_q   <= ctr_d;
      idx_q   <= idx_d;
    end
  end

  // Byte register, loaded on acceptance only
  always_ff @(posedge clk) begin
    data_q <= data_d;
  end

  a_idle_high: assert property (@(posedge clk) disable iff (rst)
    state_q == IDLE |-> tx);

endmodule

/* src/uart_echo.sv */
// UART echo top. Bytes received on rx are buffered and sent back on tx;
// tx_hold pauses the transmitter while the buffer keeps filling.

module uart_echo (
  input  logic clk,
  input  logic rst,
  input  logic rx,
  input  logic tx_hold,
  output logic tx,
  output logic busy,
  output logic frame_error,
  output logic overrun
);

  logic            rx_valid;
  logic            rx_ready;
  uart_pkg::byte_t rx_data;
  logic            tx_valid;
  logic            tx_ready;
  uart_pkg::byte_t tx_data;

  serial_rx u_rx (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .rx_data     (rx_data),
    .frame_error (frame_error),
    .overrun     (overrun)
  );

  byte_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready),
    .rx_data  (rx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_data  (tx_data)
  );

  serial_tx u_tx (
    .clk      (clk),
    .rst      (rst),
    .tx_hold  (tx_hold),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_data  (tx_data),
    .busy     (busy),
    .tx       (tx)
  );

endmodule

/* verif/tb_clock.sv */
// Free-running clock for the testbench, period 100 time units

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

endmodule

/* verif/tb_uart_echo.sv */
// Directed testbench for the UART echo top. Sends frames on rx, decodes tx
// in a background task and checks reset state, order, hold, overflow and framing.

module tb_uart_echo;

  localparam int BIT_CYC   = uart_pkg::CLK_PER_BIT;
  localparam int FRAME_CYC = 10 * uart_pkg::CLK_PER_BIT;
  localparam int DEPTH     = fifo_pkg::FIFO_DEPTH;

  logic            clk;
  logic            rst;
  logic            rx;
  logic            tx_hold;
  logic            tx;
  logic            busy;
  logic            frame_error;
  logic            overrun;
  uart_pkg::byte_t got_q[$];
  uart_pkg::byte_t exp_q[$];
  int              value_errors = 0;
  int              timeouts = 0;
  int              fe_count = 0;
  int              ov_count = 0;
  int              hold_bad = 0;
  logic            watch_hold = 1'b0;
  int unsigned     seed_val;

  tb_clock u_clk (
    .clk (clk)
  );

  uart_echo u_dut (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .tx_hold     (tx_hold),
    .tx          (tx),
    .busy        (busy),
    .frame_error (frame_error),
    .overrun     (overrun)
  );

  // Pulse tally and hold watch on each falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (frame_error) fe_count++;
      if (overrun) ov_count++;
      if (watch_hold && !(tx && busy)) hold_bad++;
    end
  end

  // Mid-bit decoder for tx that steps once per falling clock edge
  task automatic decode_tx();
    logic            prev;
    logic            active;
    int              wait_cnt;
    int              nbit;
    uart_pkg::byte_t data;
    prev     = 1'b1;
    active   = 1'b0;
    wait_cnt = 0;
    nbit     = 0;
    data     = '0;
    forever begin
      @(negedge clk);
      if (!active) begin
        if (prev === 1'b1 && tx === 1'b0) begin
          active   = 1'b1;
          wait_cnt = BIT_CYC / 2 - 1;
          nbit     = 0;
        end
      end else if (wait_cnt > 0) begin
        wait_cnt--;
      end else begin
        wait_cnt = BIT_CYC - 1;
        if (nbit == 0 && tx) begin
          active = 1'b0;
        end else if (nbit >= 1 && nbit <= uart_pkg::DATA_BITS) begin
          data[nbit-1] = tx;
        end else if (nbit == uart_pkg::DATA_BITS + 1) begin
          if (!tx) begin
            value_errors++;
            $display("[ERROR] %0t: stop bit on tx reads low", $time);
          end
          got_q.push_back(data);
          active = 1'b0;
        end
        nbit++;
      end
      prev = tx;
    end
  endtask

  task automatic check_byte(input string what, input uart_pkg::byte_t got,
                            input uart_pkg::byte_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s got %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // One bit lasts from this falling edge to the next call
  task automatic drive_bit(input logic v);
    @(negedge clk);
    rx = v;
    repeat (BIT_CYC - 1) @(negedge clk);
  endtask

  task automatic send_frame(input uart_pkg::byte_t data, input bit bad_stop);
    drive_bit(1'b0);
    for (int i = 0; i < uart_pkg::DATA_BITS; i++) drive_bit(data[i]);
    drive_bit(!bad_stop);
    if (bad_stop) drive_bit(1'b1);
  endtask

  task automatic send_random(input int n);
    uart_pkg::byte_t b;
    for (int i = 0; i < n; i++) begin
      b = uart_pkg::byte_t'($urandom);
      exp_q.push_back(b);
      send_frame(b, 1'b0);
    end
  endtask

  task automatic wait_bytes(input int n);
    int cyc;
    cyc = 0;
    while (got_q.size() < n && cyc < (n + 4) * FRAME_CYC) begin
      @(negedge clk);
      cyc++;
    end
    if (got_q.size() < n) begin
      timeouts++;
      $display("Timeout at %0t: only %0d of %0d echoed bytes arrived", $time, got_q.size(), n);
    end
  endtask

  task automatic wait_idle();
    int cyc;
    cyc = 0;
    while (busy && cyc < 2 * FRAME_CYC) begin
      @(negedge clk);
      cyc++;
    end
    if (busy) begin
      timeouts++;
      $display("Timeout at %0t: transmitter never went idle", $time);
    end
    repeat (BIT_CYC) @(negedge clk);
  endtask

  task automatic compare_echo(input string what);
    check_count({what, " byte count"}, got_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      if (i < got_q.size()) check_byte(what, got_q[i], exp_q[i]);
    end
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic test_reset();
    check_level("tx after reset", tx, 1'b1);
    check_level("busy after reset", busy, 1'b0);
    exp_q.push_back(8'hA5);
    send_frame(8'hA5, 1'b0);
    wait_bytes(1);
    wait_idle();
    compare_echo("first echo");
  endtask

  task automatic test_order();
    int fe0;
    int ov0;
    fe0 = fe_count;
    ov0 = ov_count;
    send_random(20);
    wait_bytes(20);
    wait_idle();
    compare_echo("ordered echo");
    check_count("frame errors in ordered echo", fe_count - fe0, 0);
    check_count("overruns in ordered echo", ov_count - ov0, 0);
  endtask

  task automatic test_hold();
    @(negedge clk);
    tx_hold = 1'b1;
    // Busy follows the registered hold a cycle later
    repeat (3) @(negedge clk);
    watch_hold = 1'b1;
    send_random(DEPTH);
    repeat (BIT_CYC) @(negedge clk);
    check_count("echoes during hold", got_q.size(), 0);
    watch_hold = 1'b0;
    tx_hold    = 1'b0;
    wait_bytes(DEPTH);
    wait_idle();
    compare_echo("held echo");
    check_count("cycles with tx or busy low in hold", hold_bad, 0);
  endtask

  task automatic test_overflow();
    uart_pkg::byte_t b;
    int              ov0;
    ov0 = ov_count;
    @(negedge clk);
    tx_hold = 1'b1;
    repeat (3) @(negedge clk);
    // FIFO takes DEPTH bytes and the receiver keeps one more pending
    for (int i = 0; i < DEPTH + 3; i++) begin
      b = uart_pkg::byte_t'($urandom);
      if (i <= DEPTH) exp_q.push_back(b);
      send_frame(b, 1'b0);
    end
    repeat (BIT_CYC) @(negedge clk);
    check_count("overrun pulses", ov_count - ov0, 2);
    tx_hold = 1'b0;
    wait_bytes(DEPTH + 1);
    wait_idle();
    repeat (2 * FRAME_CYC) @(negedge clk);
    compare_echo("overflow echo");
  endtask

  task automatic test_framing();
    int fe0;
    fe0 = fe_count;
    send_frame(8'h3C, 1'b1);
    repeat (2 * FRAME_CYC) @(negedge clk);
    check_count("frame error pulses", fe_count - fe0, 1);
    check_count("bytes echoed from bad frame", got_q.size(), 0);
    exp_q.push_back(8'hC3);
    send_frame(8'hC3, 1'b0);
    wait_bytes(1);
    wait_idle();
    compare_echo("echo after framing error");
  endtask

  initial begin
    rst      = 1'b1;
    rx       = 1'b1;
    tx_hold  = 1'b0;
    seed_val = 32'haf47;
    seed_val = $urandom(seed_val);
    fork
      decode_tx();
    join_none
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    test_reset();
    test_order();
    test_hold();
    test_overflow();
    test_framing();
    $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* src.f */
src/uart_pkg.sv
src/fifo_pkg.sv
src/serial_rx.sv
src/byte_fifo.sv
src/serial_tx.sv
src/uart_echo.sv
verif/tb_clock.sv
verif/tb_uart_echo.sv
